//--- Bender.yml
package:
  name: radio_ctrl

sources:
  - files:
      - design/radio_ctrl_pkg.sv
      - design/axil_settings_slave.sv
      - design/misc_settings.sv
      - design/vita_timekeeper.sv
      - design/readback_mux.sv
      - design/radio_ctrl_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_radio_ctrl.sv

//--- design/axil_settings_slave.sv
// AXI4-Lite register slave
// Accepted writes become settings strobes and reads fetch one readback word
`timescale 1ns/1ps

module axil_settings_slave import radio_ctrl_pkg::*; (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  axil_req_t             axil_req_i,
   output axil_rsp_t             axil_rsp_o,
   output set_bus_t              set_bus_o,
   output logic [RB_INDEX_W-1:0] rb_index_o,
   output logic                  rb_load_o,
   input  logic [DATA_W-1:0]     rb_word_i
);

   logic                  wr_accept;
   logic                  rd_accept;
   logic                  bvalid_q;
   logic                  set_stb_q;
   logic [SET_ADDR_W-1:0] set_addr_q;
   logic [DATA_W-1:0]     set_data_q;
   logic                  rb_load_q;
   logic                  rvalid_q;
   logic [RB_INDEX_W-1:0] rb_index_q;

   ////////////////////////////////////////////////////////////////////////////
   // Write channel

   // Address and data are taken together and held off while a response is pending
   assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         bvalid_q  <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         set_stb_q <= wr_accept;
         if (wr_accept) begin
            bvalid_q <= 1'b1;
         end else if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   // Byte address to word address
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_addr_q <= '0;
         set_data_q <= '0;
      end else if (wr_accept) begin
         set_addr_q <= axil_req_i.awaddr[SET_ADDR_W+1:2];
         set_data_q <= axil_req_i.wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read channel

   // Only one read in flight from address phase until rready
   assign rd_accept = axil_req_i.arvalid & ~rb_load_q & ~rvalid_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_load_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end else begin
         rb_load_q <= rd_accept;
         if (rb_load_q) begin
            rvalid_q <= 1'b1;
         end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_index_q <= '0;
      end else if (rd_accept) begin
         rb_index_q <= axil_req_i.araddr[RB_INDEX_W+1:2];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs

   always_comb begin
      axil_rsp_o.awready = wr_accept;
      axil_rsp_o.wready  = wr_accept;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = AXI_RESP_OKAY;
      axil_rsp_o.arready = rd_accept;
      axil_rsp_o.rvalid  = rvalid_q;
      // Readback register is stable until the next load
      axil_rsp_o.rdata   = rb_word_i;
      axil_rsp_o.rresp   = AXI_RESP_OKAY;
   end

   always_comb begin
      set_bus_o.stb  = set_stb_q;
      set_bus_o.addr = set_addr_q;
      set_bus_o.data = set_data_q;
   end

   assign rb_index_o = rb_index_q;
   assign rb_load_o  = rb_load_q;

endmodule

//--- design/misc_settings.sv
// Miscellaneous setting registers for clock, SERDES, ADC and PHY control
// Also picks each LED from hardware status or a software value
`timescale 1ns/1ps

module misc_settings import radio_ctrl_pkg::*; #(
   parameter logic [LED_W-1:0] LED_SRC_AT_RESET = 8'h1E
) (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  set_bus_t         set_bus_i,
   input  logic             run_rx_i,
   input  logic             run_tx_i,
   input  logic             clk_status_i,
   input  logic             serdes_link_up_i,
   input  logic             good_sync_i,
   output clock_ctrl_t      clock_ctrl_o,
   output serdes_ctrl_t     serdes_ctrl_o,
   output adc_ctrl_t        adc_ctrl_o,
   output logic             phy_reset_n_o,
   output logic [LED_W-1:0] leds_o
);

   // Register offsets inside the misc block, offset 5 is unused
   localparam logic [SET_ADDR_W-1:0] MISC_CLK     = SR_MISC + 8'd0;
   localparam logic [SET_ADDR_W-1:0] MISC_SERDES  = SR_MISC + 8'd1;
   localparam logic [SET_ADDR_W-1:0] MISC_ADC     = SR_MISC + 8'd2;
   localparam logic [SET_ADDR_W-1:0] MISC_LED_SW  = SR_MISC + 8'd3;
   localparam logic [SET_ADDR_W-1:0] MISC_PHY     = SR_MISC + 8'd4;
   localparam logic [SET_ADDR_W-1:0] MISC_LED_SRC = SR_MISC + 8'd6;

   clock_ctrl_t      clock_q;
   serdes_ctrl_t     serdes_q;
   adc_ctrl_t        adc_q;
   logic [LED_W-1:0] led_sw_q;
   logic             phy_reset_q;
   logic [LED_W-1:0] led_src_q;
   logic [LED_W-1:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         led_sw_q    <= '0;
         phy_reset_q <= 1'b0;
         led_src_q   <= LED_SRC_AT_RESET;
      end else if (set_bus_i.stb) begin
         // Each register keeps the low bits of the word
         case (set_bus_i.addr)
            MISC_CLK:
               clock_q <= clock_ctrl_t'(set_bus_i.data[$bits(clock_ctrl_t)-1:0]);
            MISC_SERDES:
               serdes_q <= serdes_ctrl_t'(set_bus_i.data[$bits(serdes_ctrl_t)-1:0]);
            MISC_ADC:
               adc_q <= adc_ctrl_t'(set_bus_i.data[$bits(adc_ctrl_t)-1:0]);
            MISC_LED_SW:  led_sw_q    <= set_bus_i.data[LED_W-1:0];
            MISC_PHY:     phy_reset_q <= set_bus_i.data[0];
            MISC_LED_SRC: led_src_q   <= set_bus_i.data[LED_W-1:0];
            default: ;
         endcase
      end
   end

   assign clock_ctrl_o  = clock_q;
   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;
   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset_q;

   ////////////////////////////////////////////////////////////////////////////
   // LED mux

   // Hardware status, bit 0 and the top three bits stay dark
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   // Source bit 1 selects hardware, 0 selects software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

//--- design/radio_ctrl_pkg.sv
// Shared widths, settings addresses, readback indices and bus types
// for the radio control plane

package radio_ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths

   localparam int DATA_W     = 32;
   localparam int AXI_ADDR_W = 16;
   localparam int SET_ADDR_W = 8;
   localparam int RB_INDEX_W = 4;
   localparam int LED_W      = 8;
   localparam int CLK_DIV_W  = 4;
   localparam int TIME_W     = 2 * DATA_W;

   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   // Settings bus base addresses, in words
   localparam logic [SET_ADDR_W-1:0] SR_MISC   = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_TIME64 = 8'd10;

   // Readback word indices
   localparam logic [RB_INDEX_W-1:0] RB_PINS    = 4'd9;
   localparam logic [RB_INDEX_W-1:0] RB_TIME_HI = 4'd10;
   localparam logic [RB_INDEX_W-1:0] RB_TIME_LO = 4'd11;
   localparam logic [RB_INDEX_W-1:0] RB_COMPAT  = 4'd12;
   localparam logic [RB_INDEX_W-1:0] RB_PPS_HI  = 4'd14;
   localparam logic [RB_INDEX_W-1:0] RB_PPS_LO  = 4'd15;

   ////////////////////////////////////////////////////////////////////////////
   // Types

   typedef logic [TIME_W-1:0] vita_time_t;

   // One settings write
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } set_bus_t;

   // Clock generator control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // Master side of AXI4-Lite, no byte strobes
   typedef struct packed {
      logic                  awvalid;
      logic [AXI_ADDR_W-1:0] awaddr;
      logic                  wvalid;
      logic [DATA_W-1:0]     wdata;
      logic                  bready;
      logic                  arvalid;
      logic [AXI_ADDR_W-1:0] araddr;
      logic                  rready;
   } axil_req_t;

   // Slave side of AXI4-Lite
   typedef struct packed {
      logic              awready;
      logic              wready;
      logic              bvalid;
      logic [1:0]        bresp;
      logic              arready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rsp_t;

endpackage

//--- design/radio_ctrl_top.sv
// Radio control plane top level
// AXI4-Lite slave, misc settings, VITA time and readback
`timescale 1ns/1ps

module radio_ctrl_top import radio_ctrl_pkg::*; #(
   parameter logic [LED_W-1:0] LED_SRC_AT_RESET = 8'h1E,
   parameter logic [15:0]      COMPAT_MAJOR     = 16'd7,
   parameter logic [15:0]      COMPAT_MINOR     = 16'd0
) (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  axil_req_t            axil_req_i,
   output axil_rsp_t            axil_rsp_o,
   input  logic                 pps_i,
   input  logic                 run_rx_i,
   input  logic                 run_tx_i,
   input  logic                 clk_status_i,
   input  logic                 serdes_link_up_i,
   input  logic                 sim_mode_i,
   input  logic [CLK_DIV_W-1:0] clock_divider_i,
   output clock_ctrl_t          clock_ctrl_o,
   output serdes_ctrl_t         serdes_ctrl_o,
   output adc_ctrl_t            adc_ctrl_o,
   output logic                 phy_reset_n_o,
   output logic [LED_W-1:0]     leds_o
);

   set_bus_t              set_bus;
   logic [RB_INDEX_W-1:0] rb_index;
   logic                  rb_load;
   logic [DATA_W-1:0]     rb_word;
   vita_time_t            vita_time;
   vita_time_t            vita_time_pps;
   logic                  good_sync;

   axil_settings_slave u_slave (
      .dsp_clk, .por_rst, .axil_req_i, .axil_rsp_o,
      .set_bus_o(set_bus), .rb_index_o(rb_index), .rb_load_o(rb_load), .rb_word_i(rb_word)
   );

   misc_settings #(.LED_SRC_AT_RESET(LED_SRC_AT_RESET)) u_misc (
      .dsp_clk, .por_rst, .set_bus_i(set_bus),
      .run_rx_i, .run_tx_i, .clk_status_i, .serdes_link_up_i, .good_sync_i(good_sync),
      .clock_ctrl_o, .serdes_ctrl_o, .adc_ctrl_o, .phy_reset_n_o, .leds_o
   );

   vita_timekeeper u_time (
      .dsp_clk, .por_rst, .set_bus_i(set_bus), .pps_i,
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps), .good_sync_o(good_sync)
   );

   readback_mux #(.COMPAT_MAJOR(COMPAT_MAJOR), .COMPAT_MINOR(COMPAT_MINOR)) u_readback (
      .dsp_clk, .por_rst, .rb_index_i(rb_index), .rb_load_i(rb_load),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .sim_mode_i, .clock_divider_i, .rb_word_o(rb_word)
   );

endmodule

//--- design/readback_mux.sv
// Readback word mux, registers the word picked by the read index
`timescale 1ns/1ps

module readback_mux import radio_ctrl_pkg::*; #(
   parameter logic [15:0] COMPAT_MAJOR = 16'd7,
   parameter logic [15:0] COMPAT_MINOR = 16'd0
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic [RB_INDEX_W-1:0] rb_index_i,
   input  logic                  rb_load_i,
   input  vita_time_t            vita_time_i,
   input  vita_time_t            vita_time_pps_i,
   input  logic                  sim_mode_i,
   input  logic [CLK_DIV_W-1:0]  clock_divider_i,
   output logic [DATA_W-1:0]     rb_word_o
);

   logic [DATA_W-1:0] word_sel;
   logic [DATA_W-1:0] word_q;

   // Bump the compat number when the register map changes
   always_comb begin
      case (rb_index_i)
         RB_PINS:
            word_sel = {sim_mode_i, {(DATA_W-1-CLK_DIV_W){1'b0}}, clock_divider_i};
         RB_TIME_HI: word_sel = vita_time_i[TIME_W-1:DATA_W];
         RB_TIME_LO: word_sel = vita_time_i[DATA_W-1:0];
         RB_COMPAT:  word_sel = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_PPS_HI:  word_sel = vita_time_pps_i[TIME_W-1:DATA_W];
         RB_PPS_LO:  word_sel = vita_time_pps_i[DATA_W-1:0];
         default:    word_sel = '0;
      endcase
   end

   // Held between loads so the read data stays put until rready
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         word_q <= '0;
      end else if (rb_load_i) begin
         word_q <= word_sel;
      end
   end

   assign rb_word_o = word_q;

endmodule

//--- design/vita_timekeeper.sv
// VITA 64-bit time counter, loadable over the settings bus
// Latches the time on each synchronized PPS rising edge
`timescale 1ns/1ps

module vita_timekeeper import radio_ctrl_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o
);

   localparam logic [SET_ADDR_W-1:0] TIME_HI_ADDR = SR_TIME64;
   localparam logic [SET_ADDR_W-1:0] TIME_LO_ADDR = SR_TIME64 + 8'd1;

   logic              hi_wr;
   logic              lo_wr;
   logic [DATA_W-1:0] time_hi_q;
   vita_time_t        time_q;
   logic              pps_meta;
   logic              pps_sync;
   logic              pps_prev;
   logic              pps_edge;
   vita_time_t        time_pps_q;
   logic              good_sync_q;

   assign hi_wr = set_bus_i.stb && (set_bus_i.addr == TIME_HI_ADDR);
   assign lo_wr = set_bus_i.stb && (set_bus_i.addr == TIME_LO_ADDR);

   ////////////////////////////////////////////////////////////////////////////
   // Time counter

   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_q <= '0;
      end else if (hi_wr) begin
         time_hi_q <= set_bus_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q <= '0;
      end else if (lo_wr) begin
         time_q <= {time_hi_q, set_bus_i.data};
      end else begin
         time_q <= time_q + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS capture

   // Two flop synchronizer then edge detect
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_prev <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_prev;

   // Sync flag is sticky once any edge has been seen
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_pps_q  <= '0;
         good_sync_q <= 1'b0;
      end else if (pps_edge) begin
         time_pps_q  <= time_q;
         good_sync_q <= 1'b1;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;
   assign good_sync_o     = good_sync_q;

endmodule

//--- testbench/radio_ctrl_model.svh
// Reference model of the misc registers, LED mux and readback words
`ifndef RADIO_CTRL_MODEL_SVH
`define RADIO_CTRL_MODEL_SVH

logic [4:0] m_clock;
logic [3:0] m_serdes;
logic [3:0] m_adc;
logic [7:0] m_led_sw;
logic       m_phy_reset;
logic [7:0] m_led_src;

task automatic reset_model();
   m_clock     = '0;
   m_serdes    = '0;
   m_adc       = '0;
   m_led_sw    = '0;
   m_phy_reset = 1'b0;
   m_led_src   = 8'h1E;
endtask

// Offsets 5 and 7 of the misc block hold nothing
task automatic apply_misc_write(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      8'd0: m_clock     = data[4:0];
      8'd1: m_serdes    = data[3:0];
      8'd2: m_adc       = data[3:0];
      8'd3: m_led_sw    = data[7:0];
      8'd4: m_phy_reset = data[0];
      8'd6: m_led_src   = data[7:0];
      default: ;
   endcase
endtask

function automatic logic [7:0] expected_leds(input logic rx, input logic tx, input logic clk,
                                             input logic link, input logic sync);
   logic [7:0] hw;
   logic [7:0] lit;
   hw    = 8'h00;
   hw[4] = tx;
   hw[3] = rx;
   hw[2] = clk;
   hw[1] = link & sync;
   // A set source bit picks the hardware bit for that LED
   for (int i = 0; i < 8; i++) begin
      lit[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
   end
   return lit;
endfunction

function automatic logic [31:0] expected_pins_word(input logic sim, input logic [3:0] div);
   logic [31:0] w;
   w      = 32'd0;
   w[31]  = sim;
   w[3:0] = div;
   return w;
endfunction

`endif

//--- testbench/tb_radio_ctrl.sv
// Testbench for the radio control plane
// Random AXI4-Lite traffic checked against a reference model
`timescale 1ns/1ps

module tb_radio_ctrl import radio_ctrl_pkg::*; ();

   localparam int WAIT_LIMIT = 100;
   localparam int TIME_BOUND = 20;

   logic         dsp_clk;
   logic         por_rst;
   axil_req_t    req;
   axil_rsp_t    rsp;
   logic         pps;
   logic         run_rx;
   logic         run_tx;
   logic         clk_status;
   logic         link_up;
   logic         sim_mode;
   logic [3:0]   clk_div;
   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;
   logic         phy_reset_n;
   logic [7:0]   leds;
   logic [31:0]  lfsr;
   logic         synced;
   int           errors;
   int           checks;

`include "radio_ctrl_model.svh"

   radio_ctrl_top DUT (
      .dsp_clk, .por_rst, .axil_req_i(req), .axil_rsp_o(rsp), .pps_i(pps),
      .run_rx_i(run_rx), .run_tx_i(run_tx), .clk_status_i(clk_status),
      .serdes_link_up_i(link_up), .sim_mode_i(sim_mode), .clock_divider_i(clk_div),
      .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds)
   );

   always #5 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   task automatic randomize_inputs();
      run_rx     = 1'(rand_bits(1));
      run_tx     = 1'(rand_bits(1));
      clk_status = 1'(rand_bits(1));
      link_up    = 1'(rand_bits(1));
      sim_mode   = 1'(rand_bits(1));
      clk_div    = 4'(rand_bits(4));
   endtask

   task automatic finish_run();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout at %0t: %s never happened", $time, what);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic check_outputs();
      check_value("clock_ctrl_o", m_clock, clock_ctrl);
      check_value("serdes_ctrl_o", m_serdes, serdes_ctrl);
      check_value("adc_ctrl_o", m_adc, adc_ctrl);
      check_value("phy_reset_n_o", !m_phy_reset, phy_reset_n);
      check_value("leds_o", expected_leds(run_rx, run_tx, clk_status, link_up, synced), leds);
   endtask

   // Entered and left on a falling edge
   task automatic axil_write(input logic [7:0] set_addr, input logic [31:0] data, input int stall);
      int t;
      req.awvalid = 1'b1;
      req.wvalid  = 1'b1;
      req.awaddr  = {6'(rand_bits(6)), set_addr, 2'b00};
      req.wdata   = data;
      t = 0;
      #1;
      while (!(rsp.awready && rsp.wready) && t < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         #1;
         t++;
      end
      if (!(rsp.awready && rsp.wready)) report_timeout("write address and data acceptance");
      @(negedge dsp_clk);
      t = 0;
      while (!rsp.bvalid && t < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         t++;
      end
      if (!rsp.bvalid) report_timeout("write response");
      check_value("bresp", AXI_RESP_OKAY, rsp.bresp);
      // Request stays up and must not be taken again
      repeat (stall) begin
         check_value("awready", 1'b0, rsp.awready);
         check_value("wready", 1'b0, rsp.wready);
         @(negedge dsp_clk);
         check_value("bvalid", 1'b1, rsp.bvalid);
      end
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      req.bready  = 1'b1;
      @(negedge dsp_clk);
      check_value("bvalid", 1'b0, rsp.bvalid);
      req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] index, input int stall, output logic [31:0] data);
      int t;
      req.arvalid = 1'b1;
      req.araddr  = {10'(rand_bits(10)), index, 2'b00};
      t = 0;
      #1;
      while (!rsp.arready && t < WAIT_LIMIT) begin
         @(negedge dsp_clk);
         #1;
         t++;
      end
      if (!rsp.arready) report_timeout("read address acceptance");
      @(negedge dsp_clk);
      t = 0;
      while (!rsp.rvalid && t < WAIT_LIMIT) begin
         check_value("arready", 1'b0, rsp.arready);
         @(negedge dsp_clk);
         t++;
      end
      if (!rsp.rvalid) report_timeout("read data");
      data = rsp.rdata;
      check_value("rresp", AXI_RESP_OKAY, rsp.rresp);
      repeat (stall) begin
         @(negedge dsp_clk);
         check_value("rvalid", 1'b1, rsp.rvalid);
         check_value("rdata", data, rsp.rdata);
         check_value("arready", 1'b0, rsp.arready);
      end
      req.arvalid = 1'b0;
      req.rready  = 1'b1;
      @(negedge dsp_clk);
      check_value("rvalid", 1'b0, rsp.rvalid);
      req.rready = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence

   initial begin
      logic [31:0] word;
      logic [31:0] data;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] t_before;
      logic [31:0] t_after;
      logic [7:0]  set_addr;
      lfsr       = 32'h23a38d2c;
      errors     = 0;
      checks     = 0;
      synced     = 1'b0;
      dsp_clk    = 1'b0;
      por_rst    = 1'b1;
      req        = '0;
      pps        = 1'b0;
      run_rx     = 1'b0;
      run_tx     = 1'b0;
      clk_status = 1'b0;
      link_up    = 1'b0;
      sim_mode   = 1'b0;
      clk_div    = 4'd0;
      reset_model();
      repeat (10) @(negedge dsp_clk);
      por_rst = 1'b0;
      @(negedge dsp_clk);

      check_outputs();
      axil_read(RB_COMPAT, 0, word);
      check_value("rdata compat", 32'h0007_0000, word);

      // Misc registers and LED mux before any PPS
      repeat (200) begin
         set_addr = SR_MISC + 8'(rand_bits(3));
         data     = rand_bits(32);
         randomize_inputs();
         axil_write(set_addr, data, int'(rand_bits(3)));
         apply_misc_write(set_addr, data);
         check_outputs();
      end

      // Low word kept below 2^31 so the high word never carries
      hi = rand_bits(32);
      lo = {1'b0, 31'(rand_bits(31))};
      axil_write(SR_TIME64, hi, 0);
      axil_write(SR_TIME64 + 8'd1, lo, 0);
      axil_read(RB_TIME_HI, 0, word);
      check_value("rdata time hi", hi, word);
      axil_read(RB_TIME_LO, 0, t_before);
      checks++;
      if (t_before < lo || t_before > lo + TIME_BOUND) begin
         errors++;
         $display("CHECK FAILED at %0t: rdata time lo expected %0h to %0h got %0h",
                  $time, lo, lo + TIME_BOUND, t_before);
      end
      randomize_inputs();
      axil_read(RB_PINS, 0, word);
      check_value("rdata pins", expected_pins_word(sim_mode, clk_div), word);

      // PPS capture
      pps = 1'b1;
      repeat (6) @(negedge dsp_clk);
      pps    = 1'b0;
      synced = 1'b1;
      axil_read(RB_PPS_HI, 0, word);
      check_value("rdata pps hi", hi, word);
      axil_read(RB_PPS_LO, 0, data);
      axil_read(RB_TIME_LO, 0, t_after);
      checks++;
      if (data < t_before || data > t_after) begin
         errors++;
         $display("CHECK FAILED at %0t: rdata pps lo expected %0h to %0h got %0h",
                  $time, t_before, t_after, data);
      end
      repeat (16) begin
         randomize_inputs();
         data = rand_bits(32) | 32'h2;
         axil_write(SR_MISC + 8'd6, data, int'(rand_bits(2)));
         apply_misc_write(SR_MISC + 8'd6, data);
         check_outputs();
      end

      // Long read stalls
      repeat (20) begin
         axil_read(RB_COMPAT, int'(rand_bits(4)), word);
         check_value("rdata compat", 32'h0007_0000, word);
      end
      finish_run();
   end

endmodule

//--- verilog.f
+incdir+testbench
design/radio_ctrl_pkg.sv
design/axil_settings_slave.sv
design/misc_settings.sv
design/vita_timekeeper.sv
design/readback_mux.sv
design/radio_ctrl_top.sv
testbench/tb_radio_ctrl.sv
